// File: verification/simd_driver_stimulus.txt
// mode bofs0 bofs1 abeg0 abeg1 aend0 aend1 ibeg0 ibeg1 ibeg2 iend0 iend1 iend2 (hex)
// mode 0 free flow, 1 random ack and commit delay, 2 commits withheld; ff ends the list
00 10 20 03 05 04 06 04 03 02 0a 09 07
00 00 00 00 00 03 03 03 02 01 06 07 08
01 f0 fe 02 05 05 08 03 02 01 06 07 08
00 40 40 00 00 02 03 05 05 02 05 08 05
00 00 00 01 01 03 03 03 03 03 03 03 03
00 00 00 04 04 04 06 00 00 00 04 04 04
02 08 08 00 00 02 02 00 00 00 03 03 03
01 01 02 07 00 08 04 01 00 00 04 05 06
02 00 00 09 09 0a 0a 00 00 00 01 01 01
01 33 44 00 00 03 02 02 02 00 0a 02 05
00 ff ff fe fd ff ff 0f 0e 0d 10 10 10
ff

// File: simd_driver.f
design/simd_driver_pkg.sv
design/ofs_if.sv
design/simd_driver_ctrl.sv
design/pending_counter.sv
design/offset_looper.sv
design/pipe_stage.sv
design/inst_issue.sv
design/simd_driver.sv
verification/simd_driver_checker.sv
verification/tb_simd_driver.sv

// File: Bender.yml
package:
  name: simd_driver

sources:
  - design/simd_driver_pkg.sv
  - design/ofs_if.sv
  - design/simd_driver_ctrl.sv
  - design/pending_counter.sv
  - design/offset_looper.sv
  - design/pipe_stage.sv
  - design/inst_issue.sv
  - design/simd_driver.sv
  - target: simulation
    files:
      - verification/simd_driver_checker.sv
      - verification/tb_simd_driver.sv

// File: verification/tb_simd_driver.sv
// Testbench of the SIMD driver: plays tasks from the stimulus file with back-pressure and commits
`default_nettype none

module tb_simd_driver;
	import simd_driver_pkg::*;

	// ==================================================
	// Constants and signals
	// ==================================================
	localparam int HALF_PERIOD = 20;
	localparam int DRV_DLY = 5;
	localparam int RST_CYCLES = 4;
	// Mode, bofs, aofs begin/end, id begin table, id end table
	localparam int N_FIELD = 13;
	localparam int MAX_TASK = 32;
	localparam int ACK_TIMEOUT = 3000;
	localparam logic [31:0] LFSR_SEED = 32'hc72c_fbf2;

	logic clk;
	logic arst_n;
	logic abofs_rdy;
	logic abofs_ack;
	ofs_t bofs;
	ofs_t aofs_beg;
	ofs_t aofs_end;
	id_tab_t id_begs;
	id_tab_t id_ends;
	logic inst_rdy;
	logic inst_ack;
	logic [INST_BW-1:0] pc;
	logic [WID_BW-1:0] warpid;
	ofs_t inst_aofs;
	ofs_t inst_bofs;
	logic commit;
	int task_cnt;
	int inst_cnt;
	int err_cnt;

	logic [7:0] stim [0:N_FIELD*MAX_TASK-1];
	// 0 free flow, 1 random ack and commit delay, 2 commits held back
	int mode;
	logic [31:0] lfsr;
	// Due cycles of outstanding commits
	int commit_q[$];
	int cycle;

	always #HALF_PERIOD clk = ~clk;

	// ==================================================
	// Random bits
	// ==================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit returned
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// ==================================================
	// DUT and checker
	// ==================================================
	simd_driver dut_i (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_abofs_rdy(abofs_rdy),
		.o_abofs_ack(abofs_ack),
		.i_bofs(bofs),
		.i_aofs_beg(aofs_beg),
		.i_aofs_end(aofs_end),
		.i_inst_id_begs(id_begs),
		.i_inst_id_ends(id_ends),
		.o_inst_rdy(inst_rdy),
		.i_inst_ack(inst_ack),
		.o_pc(pc),
		.o_warpid(warpid),
		.o_aofs(inst_aofs),
		.o_bofs(inst_bofs),
		.i_inst_commit_dval(commit)
	);

	simd_driver_checker u_chk (
		.i_clk(clk),
		.i_arst_n(arst_n),
		.i_abofs_rdy(abofs_rdy),
		.i_abofs_ack(abofs_ack),
		.i_bofs(bofs),
		.i_aofs_beg(aofs_beg),
		.i_aofs_end(aofs_end),
		.i_id_begs(id_begs),
		.i_id_ends(id_ends),
		.i_inst_rdy(inst_rdy),
		.i_inst_ack(inst_ack),
		.i_pc(pc),
		.i_warpid(warpid),
		.i_inst_aofs(inst_aofs),
		.i_inst_bofs(inst_bofs),
		.i_commit(commit),
		.o_task_cnt(task_cnt),
		.o_inst_cnt(inst_cnt),
		.o_err_cnt(err_cnt)
	);

	// ==================================================
	// Instruction ack and commit pulses
	// ==================================================
	always @(posedge clk) begin : bp_drive
		logic xfer;
		int cur_mode;
		// Sample at the edge, drive after the hold delay
		xfer = inst_rdy && inst_ack;
		cur_mode = mode;
		#DRV_DLY;
		if (xfer) begin
			if (cur_mode == 1) begin
				commit_q.push_back(cycle + 1 + rand_bits(3));
			end else begin
				commit_q.push_back(cycle + 1);
			end
		end
		commit = 1'b0;
		// Withheld commits trickle back once every ten cycles
		if (commit_q.size() > 0 && commit_q[0] <= cycle &&
			(cur_mode != 2 || cycle % 10 == 0)) begin
			void'(commit_q.pop_front());
			commit = 1'b1;
		end
		inst_ack = (cur_mode == 1) ? (rand_bits(1) != 0) : 1'b1;
		cycle++;
	end

	// ==================================================
	// Task sequence
	// ==================================================
	initial begin : main
		int t;
		int base;
		int cyc;
		logic got;
		logic timed_out;
		clk = 1'b0;
		arst_n = 1'b0;
		abofs_rdy = 1'b0;
		bofs = '0;
		aofs_beg = '0;
		aofs_end = '0;
		id_begs = '0;
		id_ends = '0;
		inst_ack = 1'b0;
		commit = 1'b0;
		mode = 0;
		cycle = 0;
		lfsr = LFSR_SEED;
		t = 0;
		timed_out = 1'b0;
		$readmemh("verification/simd_driver_stimulus.txt", stim);
		repeat (RST_CYCLES) @(posedge clk);
		#DRV_DLY;
		arst_n = 1'b1;
		// Marker ff or an unread entry ends the list
		while (!timed_out && t < MAX_TASK && !$isunknown(stim[t*N_FIELD]) &&
			stim[t*N_FIELD] != 8'hff) begin
			base = t * N_FIELD;
			@(posedge clk);
			#DRV_DLY;
			mode = int'(stim[base]);
			for (int d = 0; d < VDIM; d++) begin
				bofs[d] = stim[base+1+d];
				aofs_beg[d] = stim[base+3+d];
				aofs_end[d] = stim[base+5+d];
			end
			for (int k = 0; k < N_SEL; k++) begin
				id_begs[k] = stim[base+7+k][INST_BW-1:0];
				id_ends[k] = stim[base+10+k][INST_BW-1:0];
			end
			abofs_rdy = 1'b1;
			// Fields stay put until the ack
			got = 1'b0;
			cyc = 0;
			while (!got && cyc < ACK_TIMEOUT) begin
				@(posedge clk);
				got = abofs_ack;
				cyc++;
			end
			if (!got) begin
				$display("Timeout: task %0d was not acknowledged within %0d cycles",
					t, ACK_TIMEOUT);
				timed_out = 1'b1;
			end else begin
				#DRV_DLY;
				abofs_rdy = 1'b0;
				t++;
			end
		end
		if (t == 0) begin
			$display("No tasks were read from the stimulus file");
		end
		repeat (4) @(posedge clk);
		$display("Tasks %0d of %0d, instructions %0d, errors %0d",
			task_cnt, t, inst_cnt, err_cnt);
		if (!timed_out && t > 0 && task_cnt == t && err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/simd_driver_checker.sv
// Watches the driver ports, rebuilds each task's expected instruction stream and counts results
`default_nettype none

module simd_driver_checker (
	input logic i_clk,
	input logic i_arst_n,
	// Task side
	input logic i_abofs_rdy,
	input logic i_abofs_ack,
	input simd_driver_pkg::ofs_t i_bofs,
	input simd_driver_pkg::ofs_t i_aofs_beg,
	input simd_driver_pkg::ofs_t i_aofs_end,
	input simd_driver_pkg::id_tab_t i_id_begs,
	input simd_driver_pkg::id_tab_t i_id_ends,
	// Instruction side
	input logic i_inst_rdy,
	input logic i_inst_ack,
	input logic [simd_driver_pkg::INST_BW-1:0] i_pc,
	input logic [simd_driver_pkg::WID_BW-1:0] i_warpid,
	input simd_driver_pkg::ofs_t i_inst_aofs,
	input simd_driver_pkg::ofs_t i_inst_bofs,
	input logic i_commit,
	output int o_task_cnt,
	output int o_inst_cnt,
	output int o_err_cnt
);
	import simd_driver_pkg::*;

	inst_t exp_q[$];
	logic active = 1'b0;
	// Own count of issued but uncommitted instructions
	int pend = 0;
	int task_cnt = 0;
	int inst_cnt = 0;
	int err_cnt = 0;
	int task_err0 = 0;
	int task_insts = 0;

	assign o_task_cnt = task_cnt;
	assign o_inst_cnt = inst_cnt;
	assign o_err_cnt = err_cnt;

	task automatic check_field(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h (task %0d)", name, got, exp, task_cnt);
			err_cnt++;
		end
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	// Row-major walk, dimension 1 innermost; ordinal counts skipped offsets too
	task automatic build_expected();
		int n;
		int nb;
		int ne;
		int ib;
		int ie;
		inst_t e;
		n = 0;
		exp_q.delete();
		for (int a0 = i_aofs_beg[0]; a0 < int'(i_aofs_end[0]); a0++) begin
			for (int a1 = i_aofs_beg[1]; a1 < int'(i_aofs_end[1]); a1++) begin
				// Innermost dimensions sitting at their first / last value
				nb = 0;
				ne = 0;
				if (a1 == i_aofs_beg[1]) begin
					nb = (a0 == i_aofs_beg[0]) ? 2 : 1;
				end
				if (a1 == i_aofs_end[1] - 1) begin
					ne = (a0 == i_aofs_end[0] - 1) ? 2 : 1;
				end
				ib = i_id_begs[nb];
				ie = i_id_ends[ne];
				for (int p = ib; p < ie; p++) begin
					e.pc = p[INST_BW-1:0];
					e.warpid = n[WID_BW-1:0];
					e.aofs[0] = a0[WORK_BW-1:0];
					e.aofs[1] = a1[WORK_BW-1:0];
					e.bofs[0] = i_bofs[0] + a0[WORK_BW-1:0];
					e.bofs[1] = i_bofs[1] + a1[WORK_BW-1:0];
					e.islast = 1'b0;
					exp_q.push_back(e);
				end
				n++;
			end
		end
	endtask

	// ==================================================
	// Port watch
	// ==================================================
	always @(posedge i_clk) begin : watch
		inst_t e;
		logic xfer;
		if (i_arst_n) begin
			xfer = i_inst_rdy && i_inst_ack;
			// Issue must stop at the pending limit
			if (pend >= MAX_PENDING && i_inst_rdy) begin
				$display("Fail o_inst_rdy: got %h, expected %h with %0d pending",
					1'b1, 1'b0, pend);
				err_cnt++;
			end
			if (xfer) begin
				inst_cnt++;
				task_insts++;
				if (!active || exp_q.size() == 0) begin
					$display("Unexpected instruction with pc %h, none was due", i_pc);
					err_cnt++;
				end else begin
					e = exp_q.pop_front();
					check_field("o_pc", 16'(i_pc), 16'(e.pc));
					check_field("o_warpid", 16'(i_warpid), 16'(e.warpid));
					check_field("o_aofs", i_inst_aofs, e.aofs);
					check_field("o_bofs", i_inst_bofs, e.bofs);
				end
			end
			pend = pend + int'(xfer) - int'(i_commit);
			// Task boundaries
			if (i_abofs_ack) begin
				if (!active) begin
					$display("Task acknowledge arrived with no task in progress");
					err_cnt++;
				end else begin
					if (exp_q.size() != 0) begin
						$display("Task acknowledged with %0d instructions never issued",
							exp_q.size());
						err_cnt++;
					end
					if (pend != 0) begin
						$display("Task acknowledged with %0d commits outstanding", pend);
						err_cnt++;
					end
					$display("Task %0d: %0d instructions, %0d errors", task_cnt,
						task_insts, err_cnt - task_err0);
					task_cnt++;
					active = 1'b0;
				end
			end else if (!active && i_abofs_rdy) begin
				build_expected();
				active = 1'b1;
				task_err0 = err_cnt;
				task_insts = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/simd_driver.sv
// Top level of the SIMD instruction driver: task in, instruction stream out, commit pulses back
`default_nettype none

module simd_driver (
	input logic i_clk,
	input logic i_arst_n,
	// Task input, held until o_abofs_ack
	input logic i_abofs_rdy,
	output logic o_abofs_ack,
	input simd_driver_pkg::ofs_t i_bofs,
	input simd_driver_pkg::ofs_t i_aofs_beg,
	input simd_driver_pkg::ofs_t i_aofs_end,
	input simd_driver_pkg::id_tab_t i_inst_id_begs,
	input simd_driver_pkg::id_tab_t i_inst_id_ends,
	// Instruction output
	output logic o_inst_rdy,
	input logic i_inst_ack,
	output logic [simd_driver_pkg::INST_BW-1:0] o_pc,
	output logic [simd_driver_pkg::WID_BW-1:0] o_warpid,
	output simd_driver_pkg::ofs_t o_aofs,
	output simd_driver_pkg::ofs_t o_bofs,
	// One pulse per committed instruction
	input logic i_inst_commit_dval
);
	import simd_driver_pkg::*;

	// ==================================================
	// Internal signals
	// ==================================================
	logic start;
	logic empty_done;
	logic last_issued;
	logic cnt_full;
	logic cnt_zero;
	// Issue to second stage
	logic iss_rdy;
	logic iss_ack;
	inst_t iss_inst;
	// Second stage to output
	logic s1_rdy;
	logic s1_ack;
	inst_t s1_inst;

	// Looper to first stage, first stage to issue
	ofs_if lp_ofs ();
	ofs_if s0_ofs ();

	// Output gated while too many commits are outstanding
	assign o_inst_rdy = s1_rdy && !cnt_full;
	assign s1_ack = i_inst_ack && o_inst_rdy;
	assign last_issued = s1_ack && s1_inst.islast;

	assign o_pc = s1_inst.pc;
	assign o_warpid = s1_inst.warpid;
	assign o_aofs = s1_inst.aofs;
	assign o_bofs = s1_inst.bofs;

	// ==================================================
	// Blocks
	// ==================================================
	simd_driver_ctrl u_ctrl (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_abofs_rdy(i_abofs_rdy),
		.o_abofs_ack(o_abofs_ack),
		.o_start(start),
		.i_last_issued(last_issued),
		.i_empty_done(empty_done),
		.i_zero(cnt_zero)
	);

	pending_counter u_pend (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_inc(s1_ack),
		.i_dec(i_inst_commit_dval),
		.o_full(cnt_full),
		.o_zero(cnt_zero)
	);

	offset_looper u_looper (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_start(start),
		.i_aofs_beg(i_aofs_beg),
		.i_aofs_end(i_aofs_end),
		.i_id_begs(i_inst_id_begs),
		.i_id_ends(i_inst_id_ends),
		.o_empty_done(empty_done),
		.o_ofs(lp_ofs)
	);

	pipe_stage #(.payload_t(sel_ofs_t)) u_s0 (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rdy(lp_ofs.rdy),
		.o_ack(lp_ofs.ack),
		.i_data(lp_ofs.data),
		.o_rdy(s0_ofs.rdy),
		.i_ack(s0_ofs.ack),
		.o_data(s0_ofs.data)
	);

	inst_issue u_issue (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_ofs(s0_ofs),
		.i_bofs(i_bofs),
		.o_rdy(iss_rdy),
		.i_ack(iss_ack),
		.o_inst(iss_inst)
	);

	pipe_stage #(.payload_t(inst_t)) u_s1 (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rdy(iss_rdy),
		.o_ack(iss_ack),
		.i_data(iss_inst),
		.o_rdy(s1_rdy),
		.i_ack(s1_ack),
		.o_data(s1_inst)
	);

endmodule

`default_nettype wire

// File: design/inst_issue.sv
// Steps the program counter through each offset's id range and forms one instruction per pc
`default_nettype none

module inst_issue (
	input logic i_clk,
	input logic i_arst_n,
	ofs_if.snk i_ofs,
	input simd_driver_pkg::ofs_t i_bofs,
	output logic o_rdy,
	input logic i_ack,
	output simd_driver_pkg::inst_t o_inst
);
	import simd_driver_pkg::*;

	// ==================================================
	// PC stepping
	// ==================================================
	// Set once the first pc of the offset has gone out
	logic mid;
	logic [INST_BW-1:0] pc_r;
	logic [INST_BW-1:0] pc;
	logic last_pc;

	// First pc comes straight from the range begin
	assign pc = mid ? pc_r : i_ofs.data.id_beg;
	assign last_pc = (pc == i_ofs.data.id_end - 1'b1);

	// Offset is released together with its final pc
	assign o_rdy = i_ofs.rdy;
	assign i_ofs.ack = i_ack && last_pc;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			mid <= 1'b0;
		end else if (i_ack) begin
			mid <= !last_pc;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ack) begin
			pc_r <= pc + 1'b1;
		end
	end

	// ==================================================
	// Instruction fields
	// ==================================================
	always_comb begin
		o_inst.pc = pc;
		o_inst.warpid = i_ofs.data.warpid;
		o_inst.aofs = i_ofs.data.aofs;
		// b-offset wraps in WORK_BW bits
		for (int d = 0; d < VDIM; d++) begin
			o_inst.bofs[d] = i_bofs[d] + i_ofs.data.aofs[d];
		end
		// Final pc of the task's last offset
		o_inst.islast = i_ofs.data.islast && last_pc;
	end

endmodule

`default_nettype wire

// File: design/pipe_stage.sv
// One-entry ready/acknowledge register stage; the payload type is chosen at instantiation
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_rdy,
	output logic o_ack,
	input payload_t i_data,
	output logic o_rdy,
	input logic i_ack,
	output payload_t o_data
);

	logic full;

	// Take a new item when empty or being drained this cycle
	assign o_ack = i_rdy && (!full || i_ack);
	assign o_rdy = full;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			full <= 1'b0;
		end else if (o_ack) begin
			full <= 1'b1;
		end else if (i_ack) begin
			full <= 1'b0;
		end
	end

	// Data register
	always_ff @(posedge i_clk) begin
		if (o_ack) begin
			o_data <= i_data;
		end
	end

endmodule

`default_nettype wire

// File: design/offset_looper.sv
// Walks the task a-offsets row-major, selects prologue/epilogue id ranges and drops empty ones
`default_nettype none

module offset_looper (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_start,
	input simd_driver_pkg::ofs_t i_aofs_beg,
	input simd_driver_pkg::ofs_t i_aofs_end,
	input simd_driver_pkg::id_tab_t i_id_begs,
	input simd_driver_pkg::id_tab_t i_id_ends,
	output logic o_empty_done,
	ofs_if.src o_ofs
);
	import simd_driver_pkg::*;

	// ==================================================
	// Walk state
	// ==================================================
	logic walking;
	ofs_t cur;
	ofs_t nxt;
	ofs_t last;
	logic at_last;
	logic range_empty;
	logic [WID_BW-1:0] warp_cnt;
	// Id range of the current offset
	logic [SEL_BW-1:0] sel_beg;
	logic [SEL_BW-1:0] sel_end;
	logic [INST_BW-1:0] id_beg;
	logic [INST_BW-1:0] id_end;
	logic cur_empty;
	// One-entry lookahead, needed to know which offset is last
	logic hold_vld;
	sel_ofs_t hold;
	logic advance;

	// Last value per dimension, and a check for a zero-size range
	always_comb begin
		range_empty = 1'b0;
		for (int d = 0; d < VDIM; d++) begin
			last[d] = i_aofs_end[d] - 1'b1;
			if (i_aofs_end[d] <= i_aofs_beg[d]) begin
				range_empty = 1'b1;
			end
		end
	end

	// Count innermost dimensions at first / last value
	always_comb begin : edge_count
		logic run_b;
		logic run_e;
		run_b = 1'b1;
		run_e = 1'b1;
		sel_beg = '0;
		sel_end = '0;
		for (int d = VDIM - 1; d >= 0; d--) begin
			run_b = run_b && (cur[d] == i_aofs_beg[d]);
			run_e = run_e && (cur[d] == last[d]);
			if (run_b) begin
				sel_beg = sel_beg + 1'b1;
			end
			if (run_e) begin
				sel_end = sel_end + 1'b1;
			end
		end
	end

	assign id_beg = i_id_begs[sel_beg];
	assign id_end = i_id_ends[sel_end];
	assign cur_empty = (id_beg == id_end);

	// Row-major step, carry ripples from dimension 1 outward
	always_comb begin : step
		logic carry;
		carry = 1'b1;
		nxt = cur;
		for (int d = VDIM - 1; d >= 0; d--) begin
			if (carry) begin
				if (cur[d] == last[d]) begin
					nxt[d] = i_aofs_beg[d];
				end else begin
					nxt[d] = cur[d] + 1'b1;
					carry = 1'b0;
				end
			end
		end
		// Every dimension wrapped, so cur is the final offset
		at_last = carry;
	end

	// ==================================================
	// Output handshake
	// ==================================================
	// Held item leaves once a later non-empty offset exists or the walk is over
	assign o_ofs.rdy = hold_vld && (!walking || !cur_empty);

	always_comb begin
		o_ofs.data = hold;
		o_ofs.data.islast = !walking;
	end

	// Empty offsets step freely; others need room in the lookahead
	assign advance = walking && (cur_empty || !hold_vld || o_ofs.ack);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			walking <= 1'b0;
			cur <= '0;
			warp_cnt <= '0;
			hold_vld <= 1'b0;
			o_empty_done <= 1'b0;
		end else begin
			// No non-empty offset found in the whole task
			o_empty_done <= (i_start && range_empty) ||
				(advance && at_last && cur_empty && !hold_vld);
			if (i_start) begin
				walking <= !range_empty;
				cur <= i_aofs_beg;
				warp_cnt <= '0;
			end else if (advance) begin
				cur <= nxt;
				// Ordinal over all offsets, wraps at MAX_WARP
				warp_cnt <= warp_cnt + 1'b1;
				if (at_last) begin
					walking <= 1'b0;
				end
			end
			if (advance && !cur_empty) begin
				hold_vld <= 1'b1;
			end else if (o_ofs.ack) begin
				hold_vld <= 1'b0;
			end
		end
	end

	// Lookahead payload
	always_ff @(posedge i_clk) begin
		if (advance && !cur_empty) begin
			hold.aofs <= cur;
			hold.id_beg <= id_beg;
			hold.id_end <= id_end;
			hold.warpid <= warp_cnt;
			hold.islast <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: design/pending_counter.sv
// Up/down count of issued but uncommitted instructions; its full flag holds back instruction issue
`default_nettype none

module pending_counter (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_inc,
	input logic i_dec,
	output logic o_full,
	output logic o_zero
);
	import simd_driver_pkg::*;

	logic [PEND_BW-1:0] cnt;

	// Flags decode the count directly
	assign o_full = (cnt == PEND_BW'(MAX_PENDING));
	assign o_zero = (cnt == '0);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt <= '0;
		end else begin
			case ({i_inc, i_dec})
				// Issue only
				2'b10: cnt <= cnt + 1'b1;
				// Commit only
				2'b01: cnt <= cnt - 1'b1;
				// Both or neither leave the count as it is
				default: cnt <= cnt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/simd_driver_ctrl.sv
// Task controller of the driver: accepts a task, starts the offset walk, acknowledges when drained
`default_nettype none

module simd_driver_ctrl (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_abofs_rdy,
	output logic o_abofs_ack,
	output logic o_start,
	input logic i_last_issued,
	input logic i_empty_done,
	input logic i_zero
);

	// ==================================================
	// FSM
	// ==================================================
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} state_t;

	state_t state;
	// New task seen, but not the one being acknowledged right now
	logic take;

	// Task fields stay valid until the ack, so skip the ack cycle
	assign take = (state == IDLE) && i_abofs_rdy && !o_abofs_ack;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= IDLE;
			o_start <= 1'b0;
			o_abofs_ack <= 1'b0;
		end else begin
			// Both outputs are single-cycle pulses
			o_start <= take;
			o_abofs_ack <= 1'b0;
			case (state)
				IDLE: begin
					if (take) begin
						state <= RUN;
					end
				end
				RUN: begin
					// Empty task with nothing pending acks at once
					if (i_empty_done && i_zero) begin
						o_abofs_ack <= 1'b1;
						state <= IDLE;
					end else if (i_last_issued || i_empty_done) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					// Wait for every commit of this task
					if (i_zero) begin
						o_abofs_ack <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/ofs_if.sv
// Ready/acknowledge link carrying one selected offset and its id range between driver stages
`default_nettype none

interface ofs_if;
	import simd_driver_pkg::*;

	// Source holds data stable while rdy is high
	logic rdy;
	// Sink pulses ack for the transfer cycle
	logic ack;
	sel_ofs_t data;

	// Producer side
	modport src (
		output rdy,
		output data,
		input ack
	);

	// Consumer side
	modport snk (
		input rdy,
		input data,
		output ack
	);

endinterface

`default_nettype wire

// File: design/simd_driver_pkg.sv
// Shared widths, limits and payload types of the SIMD instruction driver, imported by every block
`default_nettype none

package simd_driver_pkg;

	// ==================================================
	// Sizes and limits
	// ==================================================
	// Offset dimensions, dimension 1 is innermost
	localparam int VDIM = 2;
	localparam int WORK_BW = 8;
	// Instruction memory depth
	localparam int N_INST = 16;
	// One extra value so that N_INST fits as an exclusive end
	localparam int INST_BW = $clog2(N_INST + 1);
	// Begin/end tables have one entry per count of edge dimensions
	localparam int N_SEL = VDIM + 1;
	localparam int SEL_BW = $clog2(N_SEL);
	// Issued but uncommitted instructions
	localparam int MAX_PENDING = 4;
	localparam int PEND_BW = $clog2(MAX_PENDING + 1);
	localparam int MAX_WARP = 4;
	localparam int WID_BW = $clog2(MAX_WARP);

	// ==================================================
	// Payload types
	// ==================================================
	typedef logic [VDIM-1:0][WORK_BW-1:0] ofs_t;
	typedef logic [N_SEL-1:0][INST_BW-1:0] id_tab_t;

	// One selected offset with its id range
	typedef struct packed {
		ofs_t aofs;
		logic [INST_BW-1:0] id_beg;
		logic [INST_BW-1:0] id_end;
		logic [WID_BW-1:0] warpid;
		logic islast;
	} sel_ofs_t;

	// One issued instruction
	typedef struct packed {
		logic [INST_BW-1:0] pc;
		logic [WID_BW-1:0] warpid;
		ofs_t aofs;
		ofs_t bofs;
		logic islast;
	} inst_t;

endpackage

`default_nettype wire
